//--- source/mixerPkg.sv
// Shared widths, constants and types for the CORDIC frequency mixer
// Samples are signed 16 bit two's complement, phase full scale is one turn
// The rotator output carries the CORDIC gain of about 1.647, no correction is applied
// The arctangent table assumes 45 degrees equals 8192 in the residual phase
package mixerPkg;

	// Width of the I and Q samples at the ports
	localparam int SampleWidth = 16;

	// Width of the rotation phase that reaches the rotator
	localparam int PhaseWidth = 16;

	// Internal stage width with two guard bits against CORDIC growth
	localparam int GuardWidth = SampleWidth + 2;

	// One micro-rotation per stage
	localparam int StageCount = 16;

	// Width of the NCO accumulator and of the tuning word
	localparam int AccWidth = 32;

	// Pre-rotation register plus one register per stage
	localparam int PipeLatency = StageCount + 1;

	// Arctangent of 2^-k, scaled so that 45 degrees equals 8192
	// The last entries round to one and zero and only matter for odd angles
	localparam logic [PhaseWidth-2:0] AtanTable [StageCount] = '{
		15'd8192, 15'd4836, 15'd2555, 15'd1297,
		15'd651,  15'd326,  15'd163,  15'd81,
		15'd41,   15'd20,   15'd10,   15'd5,
		15'd3,    15'd1,    15'd1,    15'd0
	};

	// Complex sample as seen at the mixer ports
	typedef struct packed {
		logic signed [SampleWidth-1:0] i;
		logic signed [SampleWidth-1:0] q;
	} sampleT;

	// Word passed from one CORDIC stage to the next
	// The phase here is the residual after quadrant folding
	typedef struct packed {
		logic                         valid;
		logic signed [GuardWidth-1:0] i;
		logic signed [GuardWidth-1:0] q;
		logic [PhaseWidth-2:0]        phase;
	} stageT;

	// Tuning command from the host
	typedef struct packed {
		logic [AccWidth-1:0] freqWord;
		logic                clearPhase;
	} tuneT;

	// States of the tuning handshake controller
	typedef enum logic [1:0] {
		TuneIdle,
		TuneApply,
		TuneAck
	} tuneStateT;

endpackage

//--- source/cordicStage.sv
// One registered CORDIC micro-rotation in rotation mode
// The residual phase must stay within plus or minus 90 degrees on entry to stage 0
// Shift must match the index of the arctangent constant on the atan port
// Only the valid bit is reset, the data words follow it
`timescale 1ns/100ps

module cordicStage #(
	parameter int Shift = 0
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [mixerPkg::PhaseWidth-2:0]   atan,
	input  mixerPkg::stageT                   stageIn,
	output mixerPkg::stageT                   stageOut
);

	import mixerPkg::*;

	// Scaled cross terms of the micro-rotation
	logic signed [GuardWidth-1:0] iShift;
	logic signed [GuardWidth-1:0] qShift;

	// Arithmetic shifts keep the sign of the guarded words
	assign iShift = stageIn.i >>> Shift;
	assign qShift = stageIn.q >>> Shift;

	always_ff @(posedge clk)
	begin
		if (reset)
			stageOut.valid <= 1'b0;
		else
			stageOut.valid <= stageIn.valid;

		// A clear sign bit means the residual angle is still positive
		if (!stageIn.phase[PhaseWidth-2])
		begin
			stageOut.i     <= stageIn.i - qShift;
			stageOut.q     <= stageIn.q + iShift;
			stageOut.phase <= stageIn.phase - atan;
		end
		else
		begin
			// Negative residual, so rotate the other way and add the angle back
			stageOut.i     <= stageIn.i + qShift;
			stageOut.q     <= stageIn.q - iShift;
			stageOut.phase <= stageIn.phase + atan;
		end
	end

endmodule

//--- source/cordicRotator.sv
// Pipelined CORDIC rotator with a valid bit that follows the data
// A sample and its phase are taken on the same edge and leave 17 cycles later
// The output keeps the CORDIC gain of about 1.647 and is truncated, not rounded
// Full scale inputs near the diagonal can overflow the 16 bit output after gain
// No back-pressure, a new sample may enter on every cycle
`timescale 1ns/100ps

module cordicRotator (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            inValid,
	input  mixerPkg::sampleT                inSample,
	input  logic [mixerPkg::PhaseWidth-1:0] phase,
	output logic                            outValid,
	output mixerPkg::sampleT                outSample
);

	import mixerPkg::*;

	// Inputs widened by the two guard bits
	logic signed [GuardWidth-1:0] iExt;
	logic signed [GuardWidth-1:0] qExt;

	// Quadrant folded sample, the input of stage 0
	stageT preRot;

	// Stage chain, entry k feeds stage k and entry k+1 is its result
	stageT pipe [StageCount+1];

	// Sign extension keeps the value and leaves headroom for the gain
	assign iExt = {{(GuardWidth-SampleWidth){inSample.i[SampleWidth-1]}}, inSample.i};
	assign qExt = {{(GuardWidth-SampleWidth){inSample.q[SampleWidth-1]}}, inSample.q};

	// Quadrant pre-rotation
	// The stages only converge within about 99 degrees, so the phase is folded first
	// Phases in the second and third quadrant are moved by half a turn
	// A half turn is the same as negating both I and Q
	always_ff @(posedge clk)
	begin
		if (reset)
			preRot.valid <= 1'b0;
		else
			preRot.valid <= inValid;

		// Dropping the top bit leaves a signed residual of plus or minus 90 degrees
		// After the fold this residual is exactly the angle still to be rotated
		preRot.phase <= phase[PhaseWidth-2:0];

		case (phase[PhaseWidth-1 -: 2])
			2'b01,
			2'b10:
			begin
				preRot.i <= -iExt;
				preRot.q <= -qExt;
			end
			default:
			begin
				preRot.i <= iExt;
				preRot.q <= qExt;
			end
		endcase
	end

	assign pipe[0] = preRot;

	// Sixteen micro-rotations, each one shift deeper with a smaller angle
	for (genvar k = 0; k < StageCount; k++)
	begin : gStage
		cordicStage #(
			.Shift(k)
		) uStage (
			.clk     (clk),
			.reset   (reset),
			.atan    (AtanTable[k]),
			.stageIn (pipe[k]),
			.stageOut(pipe[k+1])
		);
	end

	// The last stage is presented directly without an extra register
	assign outValid = pipe[StageCount].valid;

	// Drop the top guard bit and the LSB
	// This halves the gain to about 0.82 of the input scale
	assign outSample.i = pipe[StageCount].i[SampleWidth:1];
	assign outSample.q = pipe[StageCount].q[SampleWidth:1];

	// The residual phase of the last stage is only a convergence error
	// It is left unused at the output

endmodule

//--- source/phaseAccumulator.sv
// NCO phase accumulator for the mixer
// The phase advances by the tuning word once per valid sample, not once per cycle
// A sample always sees the phase held before its own edge
// A load wins over an advance on the same edge, and then no add takes place
`timescale 1ns/100ps

module phaseAccumulator (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            advance,
	input  logic                            load,
	input  mixerPkg::tuneT                  loadValue,
	output logic [mixerPkg::PhaseWidth-1:0] phase
);

	import mixerPkg::*;

	// Tuning word currently in use
	logic [AccWidth-1:0] freqWord;

	// Phase register, one full turn wraps through zero
	logic [AccWidth-1:0] phaseAcc;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			freqWord <= '0;
			phaseAcc <= '0;
		end
		else if (load)
		begin
			// New word from the controller
			freqWord <= loadValue.freqWord;

			// Optional restart at zero phase, otherwise the phase is kept
			if (loadValue.clearPhase)
				phaseAcc <= '0;
		end
		else if (advance)
		begin
			// Modulo add gives the wraparound for free
			phaseAcc <= phaseAcc + freqWord;
		end
	end

	// Only the upper bits drive the rotator
	// The lower bits keep the fractional frequency resolution
	assign phase = phaseAcc[AccWidth-1 -: PhaseWidth];

endmodule

//--- source/tuneControl.sv
// Tuning controller for the four-phase req/ack handshake
// The host must hold tune stable while tuneReq is high
// The host may only raise tuneReq while tuneAck is low
// tuneAck rises two cycles after tuneReq is seen in idle
// and falls one cycle after tuneReq is seen low
// load is a single cycle pulse that goes with the captured tuning word
`timescale 1ns/100ps

module tuneControl (
	input  logic           clk,
	input  logic           reset,
	input  logic           tuneReq,
	input  mixerPkg::tuneT tune,
	output logic           tuneAck,
	output logic           load,
	output mixerPkg::tuneT loadValue
);

	import mixerPkg::*;

	// Current and next controller state
	tuneStateT state;
	tuneStateT stateNext;

	// Next value of the registered acknowledge
	logic ackNext;

	// Tuning word latched when the request is accepted
	tuneT tuneHold;

	// Next state and acknowledge logic
	always_comb
	begin
		stateNext = state;
		ackNext   = tuneAck;

		case (state)
			TuneIdle:
			begin
				// Wait for a new request from the host
				if (tuneReq)
					stateNext = TuneApply;
			end
			TuneApply:
			begin
				// The word reaches the accumulator on this edge, then acknowledge
				stateNext = TuneAck;
				ackNext   = 1'b1;
			end
			TuneAck:
			begin
				// Hold the acknowledge until the host releases the request
				if (!tuneReq)
				begin
					stateNext = TuneIdle;
					ackNext   = 1'b0;
				end
			end
			default:
			begin
				stateNext = TuneIdle;
				ackNext   = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state   <= TuneIdle;
			tuneAck <= 1'b0;
		end
		else
		begin
			state   <= stateNext;
			tuneAck <= ackNext;
		end
	end

	// Capture the command in idle so the accumulator sees a settled word
	always_ff @(posedge clk)
	begin
		if (state == TuneIdle && tuneReq)
			tuneHold <= tune;
	end

	// One load per request, issued in the apply state
	assign load      = (state == TuneApply);
	assign loadValue = tuneHold;

endmodule

//--- source/mixerTop.sv
// Top level of the CORDIC frequency mixer
// Each valid input sample is rotated by the current NCO phase
// There is no back-pressure, outputs follow inputs by 17 cycles
// The NCO only advances on valid samples, so gaps do not move the phase
// Retuning goes through the four-phase handshake on tuneReq and tuneAck
`timescale 1ns/100ps

module mixerTop (
	input  logic             clk,
	input  logic             reset,
	input  logic             inValid,
	input  mixerPkg::sampleT inSample,
	output logic             outValid,
	output mixerPkg::sampleT outSample,
	input  logic             tuneReq,
	input  mixerPkg::tuneT   tune,
	output logic             tuneAck
);

	import mixerPkg::*;

	// Load pulse and tuning word from the controller to the NCO
	logic load;
	tuneT loadValue;

	// Current NCO phase, sampled by the rotator together with the input
	logic [PhaseWidth-1:0] phase;

	tuneControl uControl (
		.clk      (clk),
		.reset    (reset),
		.tuneReq  (tuneReq),
		.tune     (tune),
		.tuneAck  (tuneAck),
		.load     (load),
		.loadValue(loadValue)
	);

	// The NCO steps with the sample stream
	phaseAccumulator uAccumulator (
		.clk      (clk),
		.reset    (reset),
		.advance  (inValid),
		.load     (load),
		.loadValue(loadValue),
		.phase    (phase)
	);

	cordicRotator uRotator (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.inSample (inSample),
		.phase    (phase),
		.outValid (outValid),
		.outSample(outSample)
	);

endmodule

//--- verif/mixerTop_properties.sv
// Concurrent checks on the tuning handshake and the pipeline valid bit
// Bound to every mixerTop instance, all checks except the reset one pause during reset
// The latency check only starts once a full pipeline of cycles after reset has passed
`timescale 1ns/100ps

module mixerTop_properties (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic outValid,
	input logic tuneReq,
	input logic tuneAck
);

	import mixerPkg::*;

	// The acknowledge is cleared by reset
	ackAfterReset: assert property (@(posedge clk) reset |=> !tuneAck)
		else $error("tuneAck is high in the cycle after reset");

	// An acknowledge only answers a pending request
	ackRiseWithReq: assert property (@(posedge clk) disable iff (reset)
		$rose(tuneAck) |-> tuneReq)
		else $error("tuneAck rose without tuneReq");

	// The acknowledge holds while the host keeps its request
	ackHeld: assert property (@(posedge clk) disable iff (reset)
		(tuneAck && tuneReq) |=> tuneAck)
		else $error("tuneAck fell before tuneReq was released");

	// Every valid input leaves the pipeline after a fixed latency
	// The delayed input must come from a cycle after reset to be meaningful
	validLatency: assert property (@(posedge clk) disable iff (reset)
		$past(!reset, PipeLatency) |-> outValid == $past(inValid, PipeLatency))
		else $error("outValid does not follow inValid by the pipeline latency");

endmodule

bind mixerTop mixerTop_properties uProps (
	.clk     (clk),
	.reset   (reset),
	.inValid (inValid),
	.outValid(outValid),
	.tuneReq (tuneReq),
	.tuneAck (tuneAck)
);

//--- verif/mixerTb.sv
// Self-checking testbench for the CORDIC frequency mixer
// Stimulus comes from a 32 bit Galois LFSR with a fixed seed, so every run is identical
// The model tracks its own NCO and rotates each sample bit for bit from the rotator rules
// Outputs are checked on the falling edge before the edge PipeLatency after their input
`timescale 1ns/100ps

module mixerTb;

	import mixerPkg::*;

	// Upper bound for every wait loop, in clock cycles
	localparam int WaitLimit = 200;

	logic   clk;
	logic   reset;
	logic   inValid;
	sampleT inSample;
	logic   outValid;
	sampleT outSample;
	logic   tuneReq;
	tuneT   tune;
	logic   tuneAck;

	logic [31:0] lfsrState;
	int          errorCount;
	int          edgeCount;

	// Model NCO and the edge on which a request is taken
	logic [AccWidth-1:0] modelWord;
	logic [AccWidth-1:0] modelPhase;
	logic                reqPrev;
	logic                loadNext;
	tuneT                tuneTaken;

	// Expected outputs, each with the edge that took its input
	int     expEdge[$];
	sampleT expSample[$];

	mixerTop i_dut (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.inSample (inSample),
		.outValid (outValid),
		.outSample(outSample),
		.tuneReq  (tuneReq),
		.tune     (tune),
		.tuneAck  (tuneAck)
	);

	always #50 clk = ~clk;

	// One Galois step, polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		else
			return s >> 1;
	endfunction

	// Collects n random bits, one LFSR step per bit
	function automatic logic [31:0] randBits(input int n);
		int b;
		logic [31:0] v;
		v = '0;
		for (b = 0; b < n; b++)
		begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Reference rotation, fold by half a turn then 16 shift-add steps
	function automatic sampleT rotateModel(input sampleT s, input logic [PhaseWidth-1:0] ph);
		logic signed [GuardWidth-1:0] x;
		logic signed [GuardWidth-1:0] y;
		logic signed [GuardWidth-1:0] dx;
		logic signed [GuardWidth-1:0] dy;
		logic [PhaseWidth-2:0] z;
		sampleT r;
		int k;
		x = s.i;
		y = s.q;
		z = ph[PhaseWidth-2:0];
		// Top bits 01 or 10 mean the second or third quadrant
		if (ph[PhaseWidth-1] != ph[PhaseWidth-2])
		begin
			x = -x;
			y = -y;
		end
		for (k = 0; k < StageCount; k++)
		begin
			dx = y >>> k;
			dy = x >>> k;
			if (!z[PhaseWidth-2])
			begin
				x = x - dx;
				y = y + dy;
				z = z - AtanTable[k];
			end
			else
			begin
				x = x + dx;
				y = y - dy;
				z = z + AtanTable[k];
			end
		end
		r.i = x[SampleWidth:1];
		r.q = y[SampleWidth:1];
		return r;
	endfunction

	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			errorCount++;
			stopOnError($sformatf("MISMATCH %s actual %0h expected %0h",
				name, actual, expected));
		end
	endtask

	// Model of the NCO, it sees the inputs as the DUT samples them on this edge
	always @(posedge clk)
	begin
		edgeCount = edgeCount + 1;
		if (reset)
		begin
			modelWord = '0;
			modelPhase = '0;
			reqPrev = 1'b0;
			loadNext = 1'b0;
			expEdge.delete();
			expSample.delete();
		end
		else
		begin
			// A sample always uses the phase held before its edge
			if (inValid)
			begin
				expEdge.push_back(edgeCount);
				expSample.push_back(rotateModel(inSample, modelPhase[AccWidth-1 -: PhaseWidth]));
			end
			// The load edge replaces the word and skips the add
			if (loadNext)
			begin
				modelWord = tuneTaken.freqWord;
				if (tuneTaken.clearPhase)
					modelPhase = '0;
			end
			else if (inValid)
				modelPhase = modelPhase + modelWord;
			// A request is taken on its first high edge and loaded one edge later
			loadNext = tuneReq && !reqPrev;
			if (loadNext)
				tuneTaken = tune;
			reqPrev = tuneReq;
		end
	end

	// Output check, outValid must follow the input pattern exactly
	// The edge PipeLatency after the input samples what is stable on this falling edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (expEdge.size() > 0 && expEdge[0] + PipeLatency == edgeCount + 1)
			begin
				checkValue("outValid", outValid, 1);
				checkValue("outSample.i", outSample.i, expSample[0].i);
				checkValue("outSample.q", outSample.q, expSample[0].q);
				void'(expEdge.pop_front());
				void'(expSample.pop_front());
			end
			else
				checkValue("outValid", outValid, 0);
		end
	end

	// Waits on falling edges until tuneAck has the wanted level
	task automatic waitAck(input logic level, output int cycles);
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
			if (cycles > WaitLimit)
				stopOnError($sformatf("Timeout, tuneAck never went to %0d", level));
		end
		while (tuneAck !== level);
	endtask

	// One complete four-phase tuning write
	task automatic tuneWrite(input logic [AccWidth-1:0] word, input logic clear);
		int cycles;
		@(posedge clk);
		tune.freqWord <= word;
		tune.clearPhase <= clear;
		tuneReq <= 1'b1;
		waitAck(1'b1, cycles);
		// One edge until the request is seen in idle, then two more until the ack
		checkValue("tuneAck rise latency", cycles, 3);
		@(posedge clk);
		tuneReq <= 1'b0;
		waitAck(1'b0, cycles);
		checkValue("tuneAck fall latency", cycles, 2);
	endtask

	// Drives count valid samples, optionally with random idle cycles before each
	task automatic runStream(input int count, input logic gaps);
		int n;
		int idle;
		for (n = 0; n < count; n++)
		begin
			idle = gaps ? int'(randBits(2)) : 0;
			repeat (idle)
			begin
				@(posedge clk);
				inValid <= 1'b0;
			end
			@(posedge clk);
			inValid <= 1'b1;
			inSample.i <= SampleWidth'(randBits(SampleWidth));
			inSample.q <= SampleWidth'(randBits(SampleWidth));
		end
		@(posedge clk);
		inValid <= 1'b0;
	endtask

	// Waits until every expected output has been seen
	task automatic drainPipe();
		int cycles;
		cycles = 0;
		while (expEdge.size() > 0)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > WaitLimit)
				stopOnError("Timeout, expected outputs never appeared on outValid");
		end
	endtask

	initial
	begin
		logic [AccWidth-1:0] word1;
		logic [AccWidth-1:0] word2;
		logic [AccWidth-1:0] word3;
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		inSample = '0;
		tuneReq = 1'b0;
		tune = '0;
		lfsrState = 32'd81;
		errorCount = 0;
		edgeCount = 0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// Idle after reset, nothing may come out and no ack may appear
		repeat (10)
		begin
			@(negedge clk);
			checkValue("tuneAck", tuneAck, 0);
		end

		// Zero tuning from a cleared phase
		tuneWrite('0, 1'b1);
		runStream(40, 1'b0);
		drainPipe();

		// Random tuning, dense and then gapped
		tuneWrite(randBits(AccWidth), 1'b1);
		runStream(60, 1'b0);
		drainPipe();
		tuneWrite(randBits(AccWidth), 1'b0);
		runStream(60, 1'b1);
		drainPipe();

		// Retuning while samples flow, words picked before the threads start
		word1 = randBits(AccWidth);
		word2 = randBits(AccWidth);
		word3 = randBits(AccWidth);
		fork
			runStream(60, 1'b0);
			begin
				repeat (10) @(posedge clk);
				tuneWrite(word1, 1'b1);
				repeat (7) @(posedge clk);
				tuneWrite(word2, 1'b0);
			end
		join
		drainPipe();
		fork
			runStream(50, 1'b1);
			begin
				repeat (15) @(posedge clk);
				tuneWrite(word3, 1'b1);
			end
		join
		drainPipe();

		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- tb.f
source/mixerPkg.sv
source/cordicStage.sv
source/cordicRotator.sv
source/phaseAccumulator.sv
source/tuneControl.sv
source/mixerTop.sv
verif/mixerTop_properties.sv
verif/mixerTb.sv

//--- Bender.yml
# CORDIC frequency mixer with NCO and tuning handshake
package:
  name: cordic_mixer

sources:
  # Synthesizable design, package first
  - files:
      - source/mixerPkg.sv
      - source/cordicStage.sv
      - source/cordicRotator.sv
      - source/phaseAccumulator.sv
      - source/tuneControl.sv
      - source/mixerTop.sv

  # Simulation only, top module mixerTb
  - target: test
    files:
      - verif/mixerTop_properties.sv
      - verif/mixerTb.sv
